//--- pkg_vec.sv
// Vector unit sizes, data and mask types, opcodes and the command word union
`default_nettype none

package pkg_vec;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int NUM_LANES = 4;	// Lanes in the vector unit, 2 or 8 also fine
	localparam int LANE_AW   = $clog2(NUM_LANES);	// Lane select width
	localparam int DATA_W    = 32;	// Data word width
	localparam int NUM_REGS  = 8;	// Registers per lane
	localparam int REG_W     = 3;	// Register index width
	localparam int MEM_DEPTH = 16;	// Local memory words per lane
	localparam int MEM_AW    = 4;	// Local memory address width

	typedef logic [DATA_W-1:0]    data_t;	// One data word
	typedef logic [NUM_LANES-1:0] lane_t;	// One bit per lane

	////////////////////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,	// src1 + src2
		OP_SUB  = 4'd1,	// src1 - src2
		OP_AND  = 4'd2,	// src1 & src2
		OP_XOR  = 4'd3,	// src1 ^ src2
		OP_ADDS = 4'd4,	// src1 + scalar operand
		OP_ROTL = 4'd5,	// Neighbour lane's src1
		OP_LD   = 4'd6,	// Load from local memory
		OP_ST   = 4'd7,	// Store src2 to local memory
		OP_RDS  = 4'd8	// Scalar readback of src1
	} opcode_t;	// Remaining codes are no-ops that still commit

	////////////////////////////////////////////////////////////////////////////
	// Command word, 16 bits, two views
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		opcode_t          op;	// [15:12]
		logic [REG_W-1:0] dst;	// [11:9]
		logic [REG_W-1:0] src1;	// [8:6]
		logic [REG_W-1:0] src2;	// [5:3]
		logic [2:0]       spare;	// [2:0] unused
	} alu_fmt_t;

	typedef struct packed {
		opcode_t           op;	// [15:12]
		logic [REG_W-1:0]  reg_idx;	// [11:9] load destination
		logic [REG_W-1:0]  src2;	// [8:6] store data register
		logic [1:0]        spare;	// [5:4] unused
		logic [MEM_AW-1:0] addr;	// [3:0] word address
	} mem_fmt_t;

	// op sits at the same bits in both views
	typedef union packed {
		alu_fmt_t alu_fmt;	// Register-register view
		mem_fmt_t mem_fmt;	// Load/store view
	} command_u;

endpackage

`default_nettype wire

//--- lane_regfile.sv
// Per-lane register file with two combinational reads and one write port
`timescale 1ns/1ns
`default_nettype none

module lane_regfile (
	input  wire logic                      clock,
	input  wire logic                      reset,
	input  wire logic [pkg_vec::REG_W-1:0] rd_addr1,	// Read port 1 index
	input  wire logic [pkg_vec::REG_W-1:0] rd_addr2,	// Read port 2 index
	input  wire logic                      wr_en,	// Write strobe
	input  wire logic [pkg_vec::REG_W-1:0] wr_addr,	// Write index
	input  wire pkg_vec::data_t            wr_data,	// Write value
	output pkg_vec::data_t                 rd_data1,	// Read port 1 value
	output pkg_vec::data_t                 rd_data2	// Read port 2 value
);
	import pkg_vec::*;

	data_t regs [NUM_REGS];	// Register storage

	// Write at the edge after the issue cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;	// All registers start at zero
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Reads are plain muxes, new value seen next cycle
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// An X index would corrupt an unknown register
	a_wr_addr_known: assert property (
		@(posedge clock) disable iff (reset)
		wr_en |-> !$isunknown(wr_addr)
	) else $error("lane_regfile: write index unknown");

endmodule

`default_nettype wire

//--- lane_alu.sv
// Per-lane ALU with scalar and neighbour operand selection and zero flag
`timescale 1ns/1ns
`default_nettype none

module lane_alu (
	input  wire pkg_vec::opcode_t op,	// Decoded opcode
	input  wire pkg_vec::data_t   src1,	// Own src1 register
	input  wire pkg_vec::data_t   src2,	// Own src2 register
	input  wire pkg_vec::data_t   scalar,	// Broadcast scalar operand
	input  wire pkg_vec::data_t   neighbor,	// Neighbour lane's src1
	output pkg_vec::data_t        result,	// Write-back value
	output logic                  zero	// Result is zero
);
	import pkg_vec::*;

	data_t opnd_b;	// Second operand after selection
	data_t sum;	// Shared adder output
	data_t diff;	// Subtractor output

	// Scalar replaces src2 only for ADDS
	always_comb begin
		if (op == OP_ADDS) begin
			opnd_b = scalar;
		end else begin
			opnd_b = src2;
		end
	end

	assign sum  = src1 + opnd_b;	// ADD and ADDS
	assign diff = src1 - opnd_b;	// SUB

	////////////////////////////////////////////////////////////////////////////
	// Result select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (op)
			OP_ADD:  result = sum;
			OP_ADDS: result = sum;
			OP_SUB:  result = diff;
			OP_AND:  result = src1 & opnd_b;
			OP_XOR:  result = src1 ^ opnd_b;
			OP_ROTL: result = neighbor;	// Pass neighbour through
			default: result = '0;	// Not an ALU op, unused
		endcase
	end

	assign zero = (result == '0);	// Status source

endmodule

`default_nettype wire

//--- lane_mem.sv
// Per-lane local data memory, asynchronous read and clocked write
`timescale 1ns/1ns
`default_nettype none

module lane_mem (
	input  wire logic                       clock,
	input  wire logic                       we,	// Store strobe
	input  wire logic [pkg_vec::MEM_AW-1:0] addr,	// Word address
	input  wire pkg_vec::data_t             wdata,	// Store value
	output pkg_vec::data_t                  rdata	// Load value
);
	import pkg_vec::*;

	data_t mem [MEM_DEPTH];	// Contents undefined until stored

	// Store lands on the edge after issue
	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Load value is ready in the issue cycle
	assign rdata = mem[addr];

endmodule

`default_nettype wire

//--- lane_unit.sv
// One vector lane with command decode, register file, ALU, local memory and status
`timescale 1ns/1ns
`default_nettype none

module lane_unit #(
	parameter int LANE_ID = 0	// Position in the lane array
) (
	input  wire logic                                    clock,
	input  wire logic                                    reset,
	input  wire logic                                    en,	// Issue for this lane
	input  wire pkg_vec::command_u                       command,	// Broadcast command
	input  wire pkg_vec::data_t                          scalar_in,	// Broadcast scalar
	input  wire pkg_vec::data_t [pkg_vec::NUM_LANES-1:0] lane_data,	// All lanes' src1
	output pkg_vec::data_t                               lane_src1,	// Own src1 onto bus
	output logic                                         commit,	// Done, cycle after en
	output logic                                         status	// Last ALU result zero
);
	import pkg_vec::*;

	localparam int NB_ID = (LANE_ID + 1) % NUM_LANES;	// Rotate source lane

	opcode_t          op;	// Same bits in both views
	logic             is_alu;	// Writes an ALU result
	logic             is_ld;	// Writes a loaded word
	logic             is_st;	// Writes memory
	logic [REG_W-1:0] rd_addr2;	// Format dependent src2
	logic             rf_we;	// Register write strobe
	logic [REG_W-1:0] rf_waddr;	// Register write index
	data_t            rf_wdata;	// Register write value
	data_t            src1_val;	// Read port 1
	data_t            src2_val;	// Read port 2
	data_t            alu_result;
	logic             alu_zero;
	logic             mem_we;	// Store strobe
	data_t            mem_rdata;	// Load value

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	assign op     = command.alu_fmt.op;
	assign is_alu = op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDS, OP_ROTL};
	assign is_ld  = (op == OP_LD);
	assign is_st  = (op == OP_ST);

	// Store data sits higher in the memory view
	assign rd_addr2 = is_st ? command.mem_fmt.src2 : command.alu_fmt.src2;

	assign rf_we    = en & (is_alu | is_ld);
	assign rf_waddr = command.alu_fmt.dst;	// Load reg field shares these bits
	assign rf_wdata = is_ld ? mem_rdata : alu_result;
	assign mem_we   = en & is_st;

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	lane_regfile u_regfile (
		.clock    (clock),
		.reset    (reset),
		.rd_addr1 (command.alu_fmt.src1),	// Also serves RDS and ROTL
		.rd_addr2 (rd_addr2),
		.wr_en    (rf_we),
		.wr_addr  (rf_waddr),
		.wr_data  (rf_wdata),
		.rd_data1 (src1_val),
		.rd_data2 (src2_val)
	);

	lane_alu u_alu (
		.op       (op),
		.src1     (src1_val),
		.src2     (src2_val),
		.scalar   (scalar_in),
		.neighbor (lane_data[NB_ID]),	// Next lane up, wrapping
		.result   (alu_result),
		.zero     (alu_zero)
	);

	lane_mem u_mem (
		.clock (clock),
		.we    (mem_we),
		.addr  (command.mem_fmt.addr),
		.wdata (src2_val),	// Store data from src2
		.rdata (mem_rdata)
	);

	assign lane_src1 = src1_val;	// Driven even when idle

	// Commit every enabled command, status only on ALU ops
	always_ff @(posedge clock) begin
		if (reset) begin
			commit <= 1'b0;
			status <= 1'b0;
		end else begin
			commit <= en;
			if (en && is_alu) begin
				status <= alu_zero;
			end
		end
	end

	// Memory is not cleared so a load needs a stored word
	a_ld_stored: assert property (
		@(posedge clock) disable iff (reset)
		(en && is_ld) |-> !$isunknown(mem_rdata)
	) else $error("lane_unit %0d: load from a word never stored", LANE_ID);

endmodule

`default_nettype wire

//--- vector_unit.sv
// Vector unit top with lane array, commit reduction and scalar readback
`timescale 1ns/1ns
`default_nettype none

module vector_unit (
	input  wire logic              clock,
	input  wire logic              reset,
	input  wire logic              valid,	// Command strobe
	input  wire pkg_vec::lane_t    lane_en,	// Lane mask for this command
	input  wire pkg_vec::command_u command,	// Broadcast command
	input  wire pkg_vec::data_t    scalar_in,	// Scalar operand and lane select
	output pkg_vec::data_t         scalar_out,	// Readback register
	output logic                   commit_req,	// All masked lanes done
	output pkg_vec::lane_t         status	// Zero flag per lane
);
	import pkg_vec::*;

	data_t [NUM_LANES-1:0] lane_data;	// src1 of every lane
	lane_t                 lane_commit;	// Per-lane commit
	lane_t                 issued_mask;	// Mask of last cycle's command

	////////////////////////////////////////////////////////////////////////////
	// Lane array
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lane_unit #(
			.LANE_ID (i)
		) u_lane (
			.clock     (clock),
			.reset     (reset),
			.en        (valid & lane_en[i]),
			.command   (command),
			.scalar_in (scalar_in),
			.lane_data (lane_data),
			.lane_src1 (lane_data[i]),
			.commit    (lane_commit[i]),
			.status    (status[i])
		);
	end

	// Mask and readback, both one cycle after issue
	always_ff @(posedge clock) begin
		if (reset) begin
			issued_mask <= '0;
			scalar_out  <= '0;
		end else begin
			issued_mask <= valid ? lane_en : '0;	// Empty when idle
			if (valid && command.alu_fmt.op == OP_RDS) begin
				scalar_out <= lane_data[scalar_in[LANE_AW-1:0]];
			end
		end
	end

	assign commit_req = (lane_commit == issued_mask) && (|issued_mask);

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Every masked lane reports in the cycle after issue
	a_commit_after_valid: assert property (
		@(posedge clock) disable iff (reset)
		commit_req == $past(valid && (lane_en != '0))
	) else $error("vector_unit: commit_req not one cycle after a masked valid");

	// A lane outside the mask must stay silent
	a_commit_in_mask: assert property (
		@(posedge clock) disable iff (reset)
		(lane_commit & ~issued_mask) == '0
	) else $error("vector_unit: lane commit outside issued mask");

endmodule

`default_nettype wire

//--- tb_vector_unit.sv
// Random-stimulus testbench for the vector unit with a per-lane reference model and checks
`timescale 1ns/1ns
`default_nettype none

module tb_vector_unit;
	import pkg_vec::*;

	localparam int ALU_CMDS = 400;	// Random ALU commands in test 2
	localparam int LOOPS    = 100;	// Iterations in tests 3 and 4
	localparam int MIX_CMDS = 200;	// Commands in test 5
	// Upper bound of commands over all tests, readbacks included
	localparam int MAX_CMDS = NUM_LANES + NUM_REGS * NUM_LANES + ALU_CMDS * 3
		+ LOOPS * (1 + NUM_LANES) + LOOPS * (2 + NUM_LANES) + MIX_CMDS;
	localparam int CYCLE_LIMIT = 2 * MAX_CMDS + 100;

	logic     clock;
	logic     reset;
	logic     valid;
	lane_t    lane_en;
	command_u command;
	data_t    scalar_in;
	data_t    scalar_out;
	logic     commit_req;
	lane_t    status;

	data_t m_regs [NUM_LANES][NUM_REGS];	// Model register files
	data_t m_mem [NUM_LANES][MEM_DEPTH];	// Model local memories
	logic  m_written [NUM_LANES][MEM_DEPTH];	// Word has been stored
	lane_t exp_status;
	data_t exp_scalar;
	logic  exp_commit;
	int    checks = 0;
	int    errors = 0;
	int    test_errors = 0;	// Error count at start of test
	int    tests = 0;
	int    cycles = 0;

	vector_unit u_dut (
		.clock      (clock),
		.reset      (reset),
		.valid      (valid),
		.lane_en    (lane_en),
		.command    (command),
		.scalar_in  (scalar_in),
		.scalar_out (scalar_out),
		.commit_req (commit_req),
		.status     (status)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;	// 4 ns period
	end

	// Run limit
	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic command_u alu_cmd(input opcode_t op, input logic [REG_W-1:0] dst,
		input logic [REG_W-1:0] s1, input logic [REG_W-1:0] s2);
		command_u c;
		c.alu_fmt = '{op, dst, s1, s2, 3'b0};
		return c;
	endfunction

	function automatic command_u mem_cmd(input opcode_t op, input logic [REG_W-1:0] rg,
		input logic [REG_W-1:0] s2, input logic [MEM_AW-1:0] addr);
		command_u c;
		c.mem_fmt = '{op, rg, s2, 2'b0, addr};
		return c;
	endfunction

	function automatic logic [REG_W-1:0] rand_reg();
		return REG_W'($urandom);
	endfunction

	// Lanes whose word at addr holds a stored value
	function automatic lane_t written_lanes(input logic [MEM_AW-1:0] addr);
		lane_t m;
		for (int l = 0; l < NUM_LANES; l++) begin
			m[l] = m_written[l][addr];
		end
		return m;
	endfunction

	task automatic check_outputs();
		checks += 3;
		assert (commit_req === exp_commit) else begin
			$display("MISMATCH %0t commit_req expected %0b got %0b",
				$time, exp_commit, commit_req);
			errors++;
		end
		assert (status === exp_status) else begin
			$display("MISMATCH %0t status expected %b got %b", $time, exp_status, status);
			errors++;
		end
		assert (scalar_out === exp_scalar) else begin
			$display("MISMATCH %0t scalar_out expected %h got %h",
				$time, exp_scalar, scalar_out);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drive one command at the falling edge, update model, check next cycle
	////////////////////////////////////////////////////////////////////////////

	task automatic issue(input lane_t mask, input command_u cmd, input data_t scal);
		data_t   res [NUM_LANES];
		data_t   a;
		data_t   b;
		opcode_t op;
		op = cmd.alu_fmt.op;
		valid = 1'b1;
		lane_en = mask;
		command = cmd;
		scalar_in = scal;
		exp_commit = |mask;	// Empty mask never commits
		if (op == OP_RDS)
			exp_scalar = m_regs[scal[LANE_AW-1:0]][cmd.alu_fmt.src1];	// Mask ignored
		for (int l = 0; l < NUM_LANES; l++) begin	// All results from old state
			a = m_regs[l][cmd.alu_fmt.src1];
			b = m_regs[l][cmd.alu_fmt.src2];
			case (op)
				OP_ADD:  res[l] = a + b;
				OP_SUB:  res[l] = a - b;
				OP_AND:  res[l] = a & b;
				OP_XOR:  res[l] = a ^ b;
				OP_ADDS: res[l] = a + scal;
				OP_ROTL: res[l] = m_regs[(l + 1) % NUM_LANES][cmd.alu_fmt.src1];
				default: res[l] = m_mem[l][cmd.mem_fmt.addr];	// Loads only
			endcase
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			if (mask[l] && op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDS, OP_ROTL}) begin
				m_regs[l][cmd.alu_fmt.dst] = res[l];
				exp_status[l] = (res[l] == '0);
			end else if (mask[l] && op == OP_LD) begin
				m_regs[l][cmd.mem_fmt.reg_idx] = res[l];
			end else if (mask[l] && op == OP_ST) begin
				m_mem[l][cmd.mem_fmt.addr] = m_regs[l][cmd.mem_fmt.src2];
				m_written[l][cmd.mem_fmt.addr] = 1'b1;
			end
		end
		@(negedge clock);
		check_outputs();
	endtask

	task automatic idle_cycle();
		valid = 1'b0;
		lane_en = '0;
		exp_commit = 1'b0;
		@(negedge clock);
		check_outputs();
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %s done, %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		logic [REG_W-1:0]  dst;
		logic [REG_W-1:0]  src;
		logic [MEM_AW-1:0] addr;
		void'($urandom(92));	// One seed for the whole run
		reset = 1'b1;
		valid = 1'b0;
		lane_en = '0;
		command = '0;
		scalar_in = '0;
		exp_status = '0;
		exp_scalar = '0;
		exp_commit = 1'b0;
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int r = 0; r < NUM_REGS; r++)
				m_regs[l][r] = '0;
			for (int w = 0; w < MEM_DEPTH; w++)
				m_written[l][w] = 1'b0;
		end
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		check_outputs();	// Straight out of reset
		for (int l = 0; l < NUM_LANES; l++)
			issue(lane_t'($urandom), alu_cmd(OP_RDS, '0, rand_reg(), '0), data_t'(l));
		finish_test("reset");

		for (int r = 0; r < NUM_REGS; r++) begin	// Distinct values per lane
			for (int l = 0; l < NUM_LANES; l++)
				issue(lane_t'(1 << l), alu_cmd(OP_ADDS, REG_W'(r), REG_W'(r), '0), $urandom);
		end
		repeat (ALU_CMDS) begin
			issue(lane_t'($urandom), alu_cmd(opcode_t'(4'($urandom_range(3, 0))),
				rand_reg(), rand_reg(), rand_reg()), $urandom);
			repeat ($urandom_range(2, 0))
				issue(lane_t'($urandom), alu_cmd(OP_RDS, '0, rand_reg(), '0), $urandom);
		end
		finish_test("alu");

		repeat (LOOPS) begin
			dst = rand_reg();
			issue(lane_t'($urandom),
				alu_cmd(opcode_t'(($urandom_range(1, 0) != 0) ? OP_ADDS : OP_ROTL),
				dst, rand_reg(), rand_reg()), $urandom);
			for (int l = 0; l < NUM_LANES; l++)
				issue('0, alu_cmd(OP_RDS, '0, dst, '0), data_t'(l));	// Read every lane
		end
		finish_test("scalar_rotate");

		repeat (LOOPS) begin
			addr = MEM_AW'($urandom);
			dst = rand_reg();
			issue(lane_t'($urandom), mem_cmd(OP_ST, '0, rand_reg(), addr), $urandom);
			issue(lane_t'($urandom) & written_lanes(addr),
				mem_cmd(OP_LD, dst, '0, addr), $urandom);
			for (int l = 0; l < NUM_LANES; l++)
				issue('0, alu_cmd(OP_RDS, '0, dst, '0), data_t'(l));
		end
		finish_test("load_store");

		repeat (MIX_CMDS) begin
			src = rand_reg();
			case ($urandom_range(4, 0))
				0: issue(lane_t'($urandom),	// Zero result
					alu_cmd(OP_XOR, rand_reg(), src, src), $urandom);
				1: issue('0,	// Empty mask
					alu_cmd(OP_ADD, rand_reg(), src, rand_reg()), $urandom);
				2: issue(lane_t'($urandom),	// No-op
					alu_cmd(opcode_t'(4'hF), '0, src, '0), $urandom);
				3: issue(lane_t'($urandom), alu_cmd(opcode_t'(4'($urandom_range(3, 0))),
					rand_reg(), src, rand_reg()), $urandom);
				default: idle_cycle();
			endcase
		end
		idle_cycle();
		finish_test("commit_status");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vector_unit.f
pkg_vec.sv
lane_regfile.sv
lane_alu.sv
lane_mem.sv
lane_unit.sv
vector_unit.sv
tb_vector_unit.sv

//--- Makefile
# Verilator build and run of the vector unit testbench
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_vector_unit
FILELIST := vector_unit.f
LOG      := sim.log

BIN  := obj_dir/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
